/* design/core_pkg.sv */
`default_nettype none

package core_pkg;

    // ======================================================================
    // basic types
    // ======================================================================

    typedef logic [31:0] xlen_t;
    typedef logic [3:0]  reg_idx_t;  // rv32e has sixteen registers

    localparam xlen_t RESET_PC = 32'h0000_0000;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011
    } opcode_e;

    // ======================================================================
    // instruction word views
    // ======================================================================

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
    } inst_u;

    // ======================================================================
    // control, memory port and retire records
    // ======================================================================

    typedef enum logic [1:0] {ADD, SUB, PASS_B} alu_op_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    is_branch;
        logic    branch_ne;
        logic    is_jal;
        logic    halt;
        logic    illegal;
    } ctrl_t;

    typedef struct packed {
        xlen_t      addr;
        xlen_t      wdata;
        logic       write;
        logic [3:0] wstrb;
    } mem_req_t;

    typedef struct packed {
        xlen_t rdata;
    } mem_rsp_t;

    typedef struct packed {
        xlen_t    pc;
        xlen_t    inst;
        reg_idx_t rd;
        xlen_t    wdata;
        logic     reg_write;
    } retire_t;

    typedef enum logic [1:0] {FETCH, EXEC, MEM, HALT} core_state_e;

endpackage

`default_nettype wire

/* design/core_icache.sv */
`timescale 1ns/1ns
`default_nettype none

module core_icache import core_pkg::*; #(
    parameter int ICACHE_LINES = 16
) (
    input  logic  clock,
    input  logic  rst_n,
    input  logic  fetch_start,
    input  xlen_t pc,
    output logic  fetch_done,
    output inst_u inst,
    output logic  refill_start,
    output xlen_t refill_addr,
    input  logic  refill_done,
    input  xlen_t refill_data
);

    localparam int IDX_W = $clog2(ICACHE_LINES);
    localparam int TAG_W = 32 - IDX_W - 2;

    logic [ICACHE_LINES-1:0] valid_q;
    logic [TAG_W-1:0]        tag_q [ICACHE_LINES];
    xlen_t                   data_q [ICACHE_LINES];
    logic [IDX_W-1:0]        idx;
    logic [IDX_W-1:0]        fill_idx;
    logic                    hit;
    logic                    hit_q;
    xlen_t                   word_q;

    assign idx      = pc[IDX_W+1:2];
    assign fill_idx = refill_addr[IDX_W+1:2];  // missed address is kept until the fill
    assign hit      = valid_q[idx] && (tag_q[idx] == pc[31:IDX_W+2]);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            valid_q      <= '0;
            hit_q        <= 1'b0;
            refill_start <= 1'b0;
        end else begin
            hit_q        <= fetch_start && hit;
            refill_start <= fetch_start && !hit;
            if (refill_done) valid_q[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fetch_start) begin
            word_q      <= data_q[idx];
            refill_addr <= pc;
        end
        if (refill_done) begin
            tag_q[fill_idx]  <= refill_addr[31:IDX_W+2];
            data_q[fill_idx] <= refill_data;
            word_q           <= refill_data;  // holds the word through exec and mem
        end
    end

    assign fetch_done = hit_q || refill_done;
    assign inst       = refill_done ? refill_data : word_q;

endmodule

`default_nettype wire

/* design/core_idu.sv */
`timescale 1ns/1ns
`default_nettype none

module core_idu import core_pkg::*; (
    input  inst_u    inst,
    output ctrl_t    ctrl,
    output xlen_t    imm,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd
);

    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = inst.r_fmt.funct3;
    assign funct7 = inst.r_fmt.funct7;
    assign rs1    = inst.r_fmt.rs1[3:0];  // bit 4 lies outside the rv32e register file
    assign rs2    = inst.r_fmt.rs2[3:0];
    assign rd     = inst.r_fmt.rd[3:0];

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ADD;
        imm         = '0;
        case (inst.r_fmt.opcode)
            OP: begin
                ctrl.illegal   = (funct3 != 3'b000) || (funct7 != 7'h00 && funct7 != 7'h20);
                ctrl.alu_op    = funct7[5] ? SUB : ADD;
                ctrl.reg_write = !ctrl.illegal;
            end
            OP_IMM: begin  // addi is the only immediate op
                imm            = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
                ctrl.use_imm   = 1'b1;
                ctrl.illegal   = funct3 != 3'b000;
                ctrl.reg_write = !ctrl.illegal;
            end
            LUI: begin
                imm            = {funct7, inst.r_fmt.rs2, inst.r_fmt.rs1, funct3, 12'h000};
                ctrl.use_imm   = 1'b1;
                ctrl.alu_op    = PASS_B;
                ctrl.reg_write = 1'b1;
            end
            LOAD: begin
                imm            = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
                ctrl.use_imm   = 1'b1;
                ctrl.illegal   = funct3 != 3'b010;  // word access only
                ctrl.mem_read  = !ctrl.illegal;
                ctrl.reg_write = !ctrl.illegal;
            end
            STORE: begin
                imm = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
                ctrl.use_imm   = 1'b1;
                ctrl.illegal   = funct3 != 3'b010;
                ctrl.mem_write = !ctrl.illegal;
            end
            BRANCH: begin
                imm = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                       inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
                ctrl.illegal   = funct3[2:1] != 2'b00;  // beq and bne
                ctrl.is_branch = !ctrl.illegal;
                ctrl.branch_ne = funct3[0];
            end
            JAL: begin
                imm = {{12{funct7[6]}}, inst.r_fmt.rs1, funct3, inst.r_fmt.rs2[0],
                       funct7[5:0], inst.r_fmt.rs2[4:1], 1'b0};
                ctrl.is_jal    = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            SYSTEM: begin
                ctrl.illegal = inst != 32'h0010_0073;  // ebreak
                ctrl.halt    = !ctrl.illegal;
            end
            default: ctrl.illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

/* design/core_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module core_regfile import core_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     wen,
    input  reg_idx_t waddr,
    input  xlen_t    wdata,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output xlen_t    rdata1,
    output xlen_t    rdata2
);

    xlen_t regs_q [16];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs_q[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs_q[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs_q[raddr2];

endmodule

`default_nettype wire

/* design/core_exu.sv */
`timescale 1ns/1ns
`default_nettype none

module core_exu import core_pkg::*; (
    input  ctrl_t ctrl,
    input  xlen_t rs1_data,
    input  xlen_t rs2_data,
    input  xlen_t imm,
    output xlen_t result,
    output logic  branch_eq
);

    xlen_t op_b;

    assign op_b = ctrl.use_imm ? imm : rs2_data;

    always_comb begin
        case (ctrl.alu_op)
            ADD:     result = rs1_data + op_b;
            SUB:     result = rs1_data - op_b;
            PASS_B:  result = op_b;  // lui
            default: result = rs1_data + op_b;
        endcase
    end

    // branches compare the registers, never the immediate
    assign branch_eq = rs1_data == rs2_data;

endmodule

`default_nettype wire

/* design/core_lsu.sv */
`timescale 1ns/1ns
`default_nettype none

module core_lsu import core_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     refill_start,
    input  xlen_t    refill_addr,
    output logic     refill_done,
    output xlen_t    refill_data,
    input  logic     data_start,
    input  ctrl_t    ctrl,
    input  xlen_t    addr,
    input  xlen_t    store_data,
    output logic     data_done,
    output xlen_t    load_data,
    output logic     mem_req_valid,
    output mem_req_t mem_req,
    input  logic     mem_rsp_valid,
    input  mem_rsp_t mem_rsp
);

    logic pending_q;
    logic refill_owner_q;

    // refill and data never start together since the sequencer is in one state
    assign mem_req_valid = refill_start || data_start;

    always_comb begin
        if (refill_start) begin
            mem_req.addr  = refill_addr;
            mem_req.wdata = '0;
            mem_req.write = 1'b0;
            mem_req.wstrb = 4'h0;
        end else begin
            mem_req.addr  = addr;
            mem_req.wdata = store_data;
            mem_req.write = ctrl.mem_write;
            mem_req.wstrb = ctrl.mem_write ? 4'hf : 4'h0;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pending_q      <= 1'b0;
            refill_owner_q <= 1'b0;
        end else if (mem_req_valid) begin
            pending_q      <= 1'b1;
            refill_owner_q <= refill_start;
        end else if (mem_rsp_valid) begin
            pending_q <= 1'b0;
        end
    end

    assign refill_done = mem_rsp_valid && pending_q && refill_owner_q;
    assign data_done   = mem_rsp_valid && pending_q && !refill_owner_q;
    assign refill_data = mem_rsp.rdata;
    assign load_data   = mem_rsp.rdata;

endmodule

`default_nettype wire

/* design/core_pcu.sv */
`timescale 1ns/1ns
`default_nettype none

module core_pcu import core_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     fetch_done,
    input  inst_u    inst,
    input  ctrl_t    ctrl,
    input  xlen_t    imm,
    input  reg_idx_t rd,
    input  xlen_t    alu_result,
    input  logic     branch_eq,
    input  logic     data_done,
    input  xlen_t    load_data,
    output logic     fetch_start,
    output logic     data_start,
    output xlen_t    pc,
    output logic     reg_wen,
    output xlen_t    reg_wdata,
    output logic     retire_valid,
    output retire_t  retire,
    output logic     halted
);

    core_state_e state_q;
    logic        started_q;
    logic        is_mem;
    logic        stop;
    logic        taken;
    xlen_t       pc_plus4;
    xlen_t       pc_next;

    // ======================================================================
    // next pc and write-back
    // ======================================================================

    assign is_mem   = ctrl.mem_read || ctrl.mem_write;
    assign stop     = ctrl.halt || ctrl.illegal;
    assign pc_plus4 = pc + 32'd4;
    assign taken    = ctrl.is_jal || (ctrl.is_branch && (branch_eq ^ ctrl.branch_ne));
    assign pc_next  = taken ? pc + imm : pc_plus4;

    assign reg_wdata = ctrl.mem_read ? load_data : (ctrl.is_jal ? pc_plus4 : alu_result);

    assign data_start   = (state_q == EXEC) && is_mem;
    assign retire_valid = ((state_q == EXEC) && !is_mem) || ((state_q == MEM) && data_done);
    assign reg_wen      = retire_valid && ctrl.reg_write;
    assign halted       = state_q == HALT;

    always_comb begin
        retire.pc        = pc;
        retire.inst      = inst;
        retire.rd        = rd;
        retire.wdata     = reg_wdata;
        retire.reg_write = ctrl.reg_write;
    end

    // ======================================================================
    // sequencer
    // ======================================================================

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state_q     <= FETCH;
            started_q   <= 1'b0;
            fetch_start <= 1'b0;
            pc          <= RESET_PC;
        end else begin
            started_q   <= 1'b1;
            fetch_start <= !started_q || (retire_valid && !stop);  // first fetch after reset
            if (retire_valid) pc <= pc_next;
            case (state_q)
                FETCH:   if (fetch_done) state_q <= EXEC;
                EXEC:    state_q <= is_mem ? MEM : (stop ? HALT : FETCH);
                MEM:     if (data_done) state_q <= FETCH;
                default: state_q <= HALT;  // only reset leaves halt
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/core_top.sv */
`timescale 1ns/1ns
`default_nettype none

module core_top import core_pkg::*; #(
    parameter int ICACHE_LINES = 16
) (
    input  logic     clock,
    input  logic     rst_n,
    output logic     mem_req_valid,
    output mem_req_t mem_req,
    input  logic     mem_rsp_valid,
    input  mem_rsp_t mem_rsp,
    output logic     retire_valid,
    output retire_t  retire,
    output logic     halted
);

    // ======================================================================
    // fetch path
    // ======================================================================

    logic     fetch_start;
    logic     fetch_done;
    xlen_t    pc;
    inst_u    inst;
    logic     refill_start;
    xlen_t    refill_addr;
    logic     refill_done;
    xlen_t    refill_data;

    // ======================================================================
    // decode, execute and data path
    // ======================================================================

    ctrl_t    ctrl;
    xlen_t    imm;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    logic     reg_wen;
    xlen_t    reg_wdata;
    xlen_t    alu_result;
    logic     branch_eq;
    logic     data_start;
    logic     data_done;
    xlen_t    load_data;

    core_pcu i_pcu (
        .clock        (clock),
        .rst_n        (rst_n),
        .fetch_done   (fetch_done),
        .inst         (inst),
        .ctrl         (ctrl),
        .imm          (imm),
        .rd           (rd),
        .alu_result   (alu_result),
        .branch_eq    (branch_eq),
        .data_done    (data_done),
        .load_data    (load_data),
        .fetch_start  (fetch_start),
        .data_start   (data_start),
        .pc           (pc),
        .reg_wen      (reg_wen),
        .reg_wdata    (reg_wdata),
        .retire_valid (retire_valid),
        .retire       (retire),
        .halted       (halted)
    );

    core_icache #(
        .ICACHE_LINES (ICACHE_LINES)
    ) i_icache (
        .clock        (clock),
        .rst_n        (rst_n),
        .fetch_start  (fetch_start),
        .pc           (pc),
        .fetch_done   (fetch_done),
        .inst         (inst),
        .refill_start (refill_start),
        .refill_addr  (refill_addr),
        .refill_done  (refill_done),
        .refill_data  (refill_data)
    );

    core_idu i_idu (
        .inst (inst),
        .ctrl (ctrl),
        .imm  (imm),
        .rs1  (rs1),
        .rs2  (rs2),
        .rd   (rd)
    );

    core_regfile i_regfile (
        .clock  (clock),
        .rst_n  (rst_n),
        .wen    (reg_wen),
        .waddr  (rd),
        .wdata  (reg_wdata),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    core_exu i_exu (
        .ctrl      (ctrl),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .imm       (imm),
        .result    (alu_result),
        .branch_eq (branch_eq)
    );

    core_lsu i_lsu (
        .clock         (clock),
        .rst_n         (rst_n),
        .refill_start  (refill_start),
        .refill_addr   (refill_addr),
        .refill_done   (refill_done),
        .refill_data   (refill_data),
        .data_start    (data_start),
        .ctrl          (ctrl),
        .addr          (alu_result),
        .store_data    (rs2_data),
        .data_done     (data_done),
        .load_data     (load_data),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp)
    );

endmodule

`default_nettype wire

/* dv/core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module core_tb import core_pkg::*; ();

    localparam int    LINES     = 16;
    localparam int    MEM_WORDS = 256;
    localparam xlen_t EBREAK    = 32'h0010_0073;

    logic     clock;
    logic     rst_n         = 1'b0;
    logic     mem_req_valid;
    mem_req_t mem_req;
    logic     mem_rsp_valid = 1'b0;
    mem_rsp_t mem_rsp       = '0;
    logic     retire_valid;
    retire_t  retire;
    logic     halted;

    xlen_t       mem [MEM_WORDS];
    int          read_count [MEM_WORDS];
    mem_req_t    req_q [$];
    retire_t     retire_q [$];
    int unsigned rsp_wait;
    int unsigned lcg_state = 44415;

    core_top #(
        .ICACHE_LINES (LINES)
    ) i_core_top (
        .clock         (clock),
        .rst_n         (rst_n),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .retire_valid  (retire_valid),
        .retire        (retire),
        .halted        (halted)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // ======================================================================
    // instruction encoding
    // ======================================================================

    function automatic xlen_t addi(input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
    endfunction

    function automatic xlen_t add(input int rd, input int rs1, input int rs2);
        return {7'h00, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), 7'b0110011};
    endfunction

    function automatic xlen_t sub(input int rd, input int rs1, input int rs2);
        return {7'h20, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), 7'b0110011};
    endfunction

    function automatic xlen_t lui(input int rd, input int imm20);
        return {20'(imm20), 5'(rd), 7'b0110111};
    endfunction

    function automatic xlen_t lw(input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
    endfunction

    function automatic xlen_t sw(input int rs2, input int rs1, input int imm);
        logic [11:0] im;
        im = 12'(imm);
        return {im[11:5], 5'(rs2), 5'(rs1), 3'b010, im[4:0], 7'b0100011};
    endfunction

    function automatic xlen_t branch(input int rs1, input int rs2, input int off,
                                     input logic [2:0] f3);
        logic [12:0] im;
        im = 13'(off);
        return {im[12], im[10:5], 5'(rs2), 5'(rs1), f3, im[4:1], im[11], 7'b1100011};
    endfunction

    function automatic xlen_t jal(input int rd, input int off);
        logic [20:0] im;
        im = 21'(off);
        return {im[20], im[10:1], im[11], im[19:12], 5'(rd), 7'b1101111};
    endfunction

    function automatic int unsigned next_latency();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return ((lcg_state >> 16) % 4) + 1;  // one to four cycles
    endfunction

    // ======================================================================
    // memory model and retire monitor
    // ======================================================================

    always @(negedge clock) begin
        if (!rst_n) begin
            mem_rsp_valid = 1'b0;
            rsp_wait      = 0;
            req_q.delete();
            foreach (read_count[i]) read_count[i] = 0;
        end else begin
            mem_rsp_valid = 1'b0;
            if (rsp_wait > 0) begin
                rsp_wait--;
                mem_rsp_valid = (rsp_wait == 0);
            end
            if (mem_req_valid) begin
                req_q.push_back(mem_req);
                if (mem_req.write) begin
                    mem[mem_req.addr[9:2]] = mem_req.wdata;
                end else begin
                    read_count[mem_req.addr[9:2]]++;
                    mem_rsp.rdata = mem[mem_req.addr[9:2]];
                end
                rsp_wait = next_latency();
            end
        end
    end

    // a load or store retires from the response strobe up to the next rising edge
    always @(posedge clock) begin
        if (!rst_n) begin
            retire_q.delete();
        end else if (retire_valid) begin
            retire_q.push_back(retire);
        end
    end

    // ======================================================================
    // helpers
    // ======================================================================

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_equal(input xlen_t actual, input xlen_t expected, input string what);
        if (actual !== expected) begin
            abort_run($sformatf("Fail at %0t: %s, got %h, expected %h",
                                $time, what, actual, expected));
        end
    endtask

    task automatic clear_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {16'hbad0, 16'(i * 4)};  // never a legal opcode
        end
    endtask

    task automatic reset_core();
        @(negedge clock);
        rst_n = 1'b0;
        repeat (5) begin
            @(negedge clock);
            check_equal(32'({mem_req_valid, retire_valid, halted}), 32'd0, "outputs in reset");
        end
        rst_n = 1'b1;
        @(negedge clock);
        check_equal(32'({mem_req_valid, retire_valid, halted}), 32'd0, "outputs after reset");
    endtask

    task automatic run_until_halt(input int max_cycles);
        int cycles;
        cycles = 0;
        while (!halted && cycles < max_cycles) begin
            @(negedge clock);
            cycles++;
        end
        if (!halted) abort_run("core did not retire or halt in time");
    endtask

    // ======================================================================
    // directed tests
    // ======================================================================

    task automatic reset_and_first_fetch();
        clear_memory();
        mem[0] = EBREAK;
        reset_core();
        run_until_halt(100);
        check_equal(req_q[0].addr, RESET_PC, "first request address");
        check_equal(32'(req_q[0].write), 32'd0, "first request is a read");
        check_equal(retire_q.size(), 1, "retire count");
        check_equal(retire_q[0].pc, RESET_PC, "first retire pc");
    endtask

    task automatic arithmetic_sequence();
        xlen_t a = 100;
        xlen_t b = -7;
        xlen_t u = 32'h12345 << 12;
        clear_memory();
        mem[0] = addi(1, 0, 100);
        mem[1] = addi(2, 0, -7);
        mem[2] = add(3, 1, 2);
        mem[3] = sub(4, 2, 1);
        mem[4] = lui(5, 32'h12345);
        mem[5] = add(6, 5, 1);
        mem[6] = addi(0, 1, 5);  // x0 stays zero
        mem[7] = add(7, 0, 0);
        mem[8] = EBREAK;
        reset_core();
        run_until_halt(500);
        check_equal(retire_q.size(), 9, "arith retire count");
        check_equal(retire_q[0].wdata, a, "addi positive");
        check_equal(retire_q[1].wdata, b, "addi negative");
        check_equal(retire_q[2].wdata, a + b, "add");
        check_equal(retire_q[3].wdata, b - a, "sub");
        check_equal(retire_q[4].wdata, u, "lui");
        check_equal(retire_q[5].wdata, u + a, "add after lui");
        check_equal(retire_q[7].wdata, 32'd0, "read of x0");
    endtask

    task automatic store_then_load();
        xlen_t    stored = (32'hcafe1 << 12) + 32'h2b3;
        mem_req_t wr;
        int       writes = 0;
        clear_memory();
        mem[0] = addi(1, 0, 32'h200);
        mem[1] = lui(2, 32'hcafe1);
        mem[2] = addi(2, 2, 32'h2b3);
        mem[3] = sw(2, 1, 8);
        mem[4] = lw(3, 1, 8);
        mem[5] = EBREAK;
        reset_core();
        run_until_halt(500);
        foreach (req_q[i]) begin
            if (req_q[i].write) begin
                wr = req_q[i];
                writes++;
            end
        end
        check_equal(writes, 1, "store request count");
        check_equal(wr.addr, 32'h208, "store address");
        check_equal(wr.wdata, stored, "store data");
        check_equal(32'(wr.wstrb), 32'hf, "store strobe");
        check_equal(retire_q.size(), 6, "memory retire count");
        check_equal(32'(retire_q[3].reg_write), 32'd0, "store writes no register");
        check_equal(retire_q[4].wdata, stored, "load data");
        check_equal(32'(retire_q[4].rd), 32'd3, "load destination");
        check_equal(32'(retire_q[4].reg_write), 32'd1, "load writes a register");
    endtask

    task automatic branch_and_jump();
        xlen_t exp_pc [6] = '{0, 4, 8, 8 + 12, 20 + 4, 24 + 12};
        clear_memory();
        mem[0] = addi(1, 0, 5);
        mem[1] = addi(2, 0, 5);
        mem[2] = branch(1, 2, 12, 3'b000);  // beq taken
        mem[5] = branch(1, 2, 8, 3'b001);   // bne not taken
        mem[6] = jal(4, 12);
        mem[9] = EBREAK;
        reset_core();
        run_until_halt(500);
        check_equal(retire_q.size(), 6, "branch retire count");
        foreach (exp_pc[i]) check_equal(retire_q[i].pc, exp_pc[i], "control flow pc");
        check_equal(retire_q[4].wdata, exp_pc[4] + 4, "jal link value");
    endtask

    task automatic loop_from_cache();
        xlen_t exp_pc [12] = '{0, 4, 8, 12, 16, 8, 12, 16, 8, 12, 16, 20};
        clear_memory();
        mem[0] = addi(1, 0, 3);
        mem[1] = addi(2, 0, 0);
        mem[2] = addi(2, 2, 7);
        mem[3] = addi(1, 1, -1);
        mem[4] = branch(1, 0, -8, 3'b001);
        mem[5] = EBREAK;
        reset_core();
        run_until_halt(1000);
        check_equal(retire_q.size(), 12, "loop retire count");
        foreach (exp_pc[i]) check_equal(retire_q[i].pc, exp_pc[i], "loop pc");
        for (int n = 1; n <= 3; n++) begin
            check_equal(retire_q[3 * n - 1].wdata, 7 * n, "loop sum");
        end
        for (int w = 0; w < 6; w++) begin
            check_equal(read_count[w], 1, $sformatf("fetch reads of word %0d", w));
        end
    endtask

    task automatic halt_on_ebreak();
        int reqs;
        int rets;
        clear_memory();
        mem[0] = addi(1, 0, 9);
        mem[1] = EBREAK;
        reset_core();
        run_until_halt(200);
        check_equal(retire_q.size(), 2, "halt retire count");
        check_equal(retire_q[1].inst, EBREAK, "ebreak retired");
        reqs = req_q.size();
        rets = retire_q.size();
        repeat (50) begin
            @(negedge clock);
            check_equal(32'(halted), 32'd1, "halted held");
        end
        check_equal(req_q.size(), reqs, "requests after halt");
        check_equal(retire_q.size(), rets, "retires after halt");
    endtask

    initial begin
        reset_and_first_fetch();
        arithmetic_sequence();
        store_then_load();
        branch_and_jump();
        loop_from_cache();
        halt_on_ebreak();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
design/core_pkg.sv
design/core_icache.sv
design/core_idu.sv
design/core_regfile.sv
design/core_exu.sv
design/core_lsu.sv
design/core_pcu.sv
design/core_top.sv
dv/core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "RESULT: FAIL"; exit 1; \
	elif ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "RESULT: FAIL (no pass message)"; exit 1; \
	else \
		echo "RESULT: PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
